// ==== filelist.f ====
+incdir+logic
logic/wdt_pkg.sv
logic/wdt_cfg_if.sv
logic/wdt_regs.sv
logic/wdt_counter.sv
logic/wdt_ctrl.sv
logic/watchdog.sv
test/watchdog_tb.sv

// ==== logic/watchdog.sv ====
// Watchdog timer top level
// Peripheral bus WDTCTL register, tick-enabled 16-bit counter,
// interval interrupt and watchdog reset generation

module watchdog (
  input  logic               mclk,            // Main clock
  input  logic               puc_rst,         // System reset
  input  wdt_pkg::per_addr_t per_addr,        // Word address
  input  wdt_pkg::per_data_t per_din,         // Write data
  input  logic               per_en,          // Bus access
  input  logic [1:0]         per_we,          // Byte write enables
  input  logic               smclk_en,        // SMCLK tick
  input  logic               aclk_en,         // ACLK tick
  input  logic               dbg_freeze,      // Debugger halt
  input  logic               wdtie,           // Interrupt enable
  input  logic               wdtifg_sw_set,   // Software flag set
  input  logic               wdtifg_sw_clr,   // Software flag clear
  input  logic               wdtifg_irq_clr,  // Clear on interrupt accept
  output wdt_pkg::per_data_t per_dout,        // Read data
  output logic               wdtifg,          // Interrupt flag
  output logic               wdt_irq,         // Interval interrupt
  output logic               wdt_reset        // Reset request
);

  wdt_cfg_if cfg_i ();  // Register fields and strobes

  logic interval_evt;  // Counter expiry

  //--------------------------------------------------------------------------
  // Register block
  //--------------------------------------------------------------------------

  wdt_regs regs_i (
    .mclk     (mclk),
    .puc_rst  (puc_rst),
    .per_addr (per_addr),
    .per_din  (per_din),
    .per_en   (per_en),
    .per_we   (per_we),
    .per_dout (per_dout),
    .cfg      (cfg_i.regs)
  );

  //--------------------------------------------------------------------------
  // Counter and flag logic
  //--------------------------------------------------------------------------

  wdt_counter counter_i (
    .mclk         (mclk),
    .puc_rst      (puc_rst),
    .smclk_en     (smclk_en),
    .aclk_en      (aclk_en),
    .dbg_freeze   (dbg_freeze),
    .cfg          (cfg_i.counter),
    .interval_evt (interval_evt)
  );

  wdt_ctrl ctrl_i (
    .mclk           (mclk),
    .puc_rst        (puc_rst),
    .interval_evt   (interval_evt),
    .wdtie          (wdtie),
    .wdtifg_sw_set  (wdtifg_sw_set),
    .wdtifg_sw_clr  (wdtifg_sw_clr),
    .wdtifg_irq_clr (wdtifg_irq_clr),
    .cfg            (cfg_i.ctrl),
    .wdtifg         (wdtifg),
    .wdt_irq        (wdt_irq),
    .wdt_reset      (wdt_reset)
  );

endmodule

// ==== logic/wdt_cfg_if.sv ====
// Watchdog configuration interface
// Carries decoded WDTCTL fields and the write strobes from the
// register block to the counter and control blocks

interface wdt_cfg_if;

  import wdt_pkg::*;

  // Levels from stored WDTCTL
  logic          hold;
  logic          tmsel;
  logic          ssel;
  wdt_interval_e isx;

  // Single cycle strobes
  logic cnt_clr;   // Counter restart
  logic pw_error;  // Bad write key

  // Driven by the register block
  modport regs (output hold, tmsel, ssel, isx, cnt_clr, pw_error);

  // Counter side
  modport counter (input hold, ssel, isx, cnt_clr);

  // Flag and reset side
  modport ctrl (input tmsel, pw_error);

endinterface

// ==== logic/wdt_config.svh ====
// Watchdog timer configuration
// Bus placement of WDTCTL, write key, read-back identifier and
// the mask of writable control bits

`ifndef WDT_CONFIG_SVH
`define WDT_CONFIG_SVH

//--------------------------------------------------------------------------
// Peripheral bus placement
//--------------------------------------------------------------------------

// Byte address of WDTCTL
`define WDT_BASE_ADDR 16'h0120

// Low address bits ignored for block select
`define WDT_DEC_WD 2

//--------------------------------------------------------------------------
// WDTCTL access
//--------------------------------------------------------------------------

// High byte required on every write
`define WDT_PASSWORD 8'h5A

// High byte returned on every read
`define WDT_READ_ID 8'h69

// Keeps hold, tmsel, ssel and isx
// NMI bits and self-clearing cntcl never stored
`define WDTCTL_WR_MASK 8'h97

`endif

// ==== logic/wdt_counter.sv ====
// Watchdog counter
// Selects the tick source, runs the 16-bit count and flags the
// end of the interval chosen by isx

module wdt_counter (
  input  logic       mclk,          // Main clock
  input  logic       puc_rst,       // System reset
  input  logic       smclk_en,      // SMCLK tick
  input  logic       aclk_en,       // ACLK tick
  input  logic       dbg_freeze,    // Debugger halt
  wdt_cfg_if.counter cfg,           // Decoded controls
  output logic       interval_evt   // Interval end strobe
);

  import wdt_pkg::*;

  logic        src_en;   // Selected tick
  logic        cnt_inc;  // Advance this cycle
  logic [15:0] cnt_q;
  logic [15:0] cnt_nxt;
  logic        tap;      // Selected bit of next count

  //--------------------------------------------------------------------------
  // Tick source and run control
  //--------------------------------------------------------------------------

  assign src_en  = cfg.ssel ? aclk_en : smclk_en;
  assign cnt_inc = src_en & ~cfg.hold & ~dbg_freeze;  // Hold or debug stops it

  //--------------------------------------------------------------------------
  // 16-bit counter
  //--------------------------------------------------------------------------

  assign cnt_nxt = cnt_q + 16'd1;

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      cnt_q <= '0;
    end else if (cfg.cnt_clr || interval_evt) begin
      cnt_q <= '0;  // Restart on write or expiry
    end else if (cnt_inc) begin
      cnt_q <= cnt_nxt;
    end
  end

  //--------------------------------------------------------------------------
  // Interval tap
  //--------------------------------------------------------------------------

  // Look at next count so the strobe lands on the ending tick
  always_comb begin
    case (cfg.isx)
      ivl_32k: tap = cnt_nxt[15];
      ivl_8k:  tap = cnt_nxt[13];
      ivl_512: tap = cnt_nxt[9];
      default: tap = cnt_nxt[6];  // ivl_64
    endcase
  end

  assign interval_evt = tap & cnt_inc;

  // Held counter never expires
  a_no_evt_in_hold : assert property (
    @(posedge mclk) disable iff (puc_rst)
    cfg.hold |-> !interval_evt
  );

endmodule

// ==== logic/wdt_ctrl.sv ====
// Watchdog control
// Keeps the interrupt flag, gates the interval interrupt and
// issues the single cycle reset pulse in watchdog mode

module wdt_ctrl (
  input  logic    mclk,            // Main clock
  input  logic    puc_rst,         // System reset
  input  logic    interval_evt,    // Interval end
  input  logic    wdtie,           // Interrupt enable
  input  logic    wdtifg_sw_set,   // Software flag set
  input  logic    wdtifg_sw_clr,   // Software flag clear
  input  logic    wdtifg_irq_clr,  // Clear on interrupt accept
  wdt_cfg_if.ctrl cfg,             // Decoded controls
  output logic    wdtifg,          // Interrupt flag
  output logic    wdt_irq,         // Interval interrupt
  output logic    wdt_reset        // Reset request
);

  logic ifg_set;
  logic ifg_clr;
  logic rst_req;

  //--------------------------------------------------------------------------
  // Interrupt flag
  //--------------------------------------------------------------------------

  assign ifg_set = interval_evt | cfg.pw_error | wdtifg_sw_set;

  // Accept clear only matters in interval mode
  assign ifg_clr = (wdtifg_irq_clr & cfg.tmsel) | wdtifg_sw_clr;

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      wdtifg <= 1'b0;
    end else if (ifg_set) begin
      wdtifg <= 1'b1;  // Set wins
    end else if (ifg_clr) begin
      wdtifg <= 1'b0;
    end
  end

  assign wdt_irq = cfg.tmsel & wdtifg & wdtie;  // Interval mode only

  //--------------------------------------------------------------------------
  // Reset pulse
  //--------------------------------------------------------------------------

  // Bad key in any mode, any set source in watchdog mode
  assign rst_req = cfg.pw_error | (ifg_set & ~cfg.tmsel);

  // Back-to-back requests merge into one pulse
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      wdt_reset <= 1'b0;
    end else begin
      wdt_reset <= rst_req & ~wdt_reset;
    end
  end

  a_reset_one_cycle : assert property (
    @(posedge mclk) disable iff (puc_rst)
    wdt_reset |=> !wdt_reset
  );

endmodule

// ==== logic/wdt_pkg.sv ====
// Watchdog timer types
// Peripheral bus data types, WDTCTL layout and the interval
// tap encoding shared by the register and counter blocks

package wdt_pkg;

  //--------------------------------------------------------------------------
  // Peripheral bus
  //--------------------------------------------------------------------------

  typedef logic [13:0] per_addr_t;  // Word address
  typedef logic [15:0] per_data_t;  // Bus data

  //--------------------------------------------------------------------------
  // Interval select
  //--------------------------------------------------------------------------

  // Counter bit that ends an interval
  typedef enum logic [1:0] {
    ivl_32k = 2'd0,  // Bit 15
    ivl_8k  = 2'd1,  // Bit 13
    ivl_512 = 2'd2,  // Bit 9
    ivl_64  = 2'd3   // Bit 6
  } wdt_interval_e;

  //--------------------------------------------------------------------------
  // WDTCTL low byte
  //--------------------------------------------------------------------------

  typedef struct packed {
    logic          hold;   // Stop counter
    logic          nmies;  // Not implemented
    logic          nmi;    // Not implemented
    logic          tmsel;  // 1 interval mode, 0 watchdog mode
    logic          cntcl;  // Counter clear, write only
    logic          ssel;   // 1 aclk_en, 0 smclk_en
    wdt_interval_e isx;    // Interval tap
  } wdtctl_t;

endpackage

// ==== logic/wdt_regs.sv ====
// Watchdog register block
// Decodes the peripheral bus, checks the write password, holds
// WDTCTL and returns it with the read identifier

`include "wdt_config.svh"

module wdt_regs (
  input  logic                mclk,      // Main clock
  input  logic                puc_rst,   // System reset
  input  wdt_pkg::per_addr_t  per_addr,  // Word address
  input  wdt_pkg::per_data_t  per_din,   // Write data
  input  logic                per_en,    // Bus access
  input  logic [1:0]          per_we,    // Byte write enables
  output wdt_pkg::per_data_t  per_dout,  // Read data
  wdt_cfg_if.regs             cfg        // Decoded controls
);

  import wdt_pkg::*;

  localparam logic [15:0] BASE_ADDR = `WDT_BASE_ADDR;
  localparam int          DEC_WD    = `WDT_DEC_WD;

  //--------------------------------------------------------------------------
  // Address decode
  //--------------------------------------------------------------------------

  logic              blk_sel;  // Upper address match
  logic [DEC_WD-1:0] reg_off;  // Byte offset inside block
  logic              ctl_hit;  // WDTCTL addressed
  logic              reg_wr;
  logic              reg_rd;
  logic              wr_ok;    // Write with good key
  wdtctl_t           wdtctl_q;

  // Word address lines up with byte address shifted by one
  assign blk_sel = per_en & (per_addr[13:DEC_WD-1] == BASE_ADDR[14:DEC_WD]);
  assign reg_off = {per_addr[DEC_WD-2:0], 1'b0};
  assign ctl_hit = blk_sel & (reg_off == '0);

  assign reg_wr = ctl_hit & (|per_we);
  assign reg_rd = ctl_hit & ~(|per_we);

  // Password check on high byte
  assign cfg.pw_error = reg_wr & (per_din[15:8] != `WDT_PASSWORD);
  assign wr_ok        = reg_wr & ~cfg.pw_error;

  //--------------------------------------------------------------------------
  // WDTCTL storage
  //--------------------------------------------------------------------------

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      wdtctl_q <= '0;  // Watchdog mode, 32k interval
    end else if (wr_ok) begin
      wdtctl_q <= wdtctl_t'(per_din[7:0] & `WDTCTL_WR_MASK);
    end
  end

  // Stored fields out as levels
  assign cfg.hold  = wdtctl_q.hold;
  assign cfg.tmsel = wdtctl_q.tmsel;
  assign cfg.ssel  = wdtctl_q.ssel;
  assign cfg.isx   = wdtctl_q.isx;

  // cntcl acts on the write itself, never stored
  // Bad key restarts the count as well
  assign cfg.cnt_clr = (wr_ok & per_din[3]) | cfg.pw_error;

  //--------------------------------------------------------------------------
  // Read data
  //--------------------------------------------------------------------------

  assign per_dout = reg_rd ? {`WDT_READ_ID, wdtctl_q} : '0;  // Zero when idle

  // Rejected write leaves WDTCTL as it was
  a_pw_error_no_update : assert property (
    @(posedge mclk) disable iff (puc_rst)
    cfg.pw_error |=> $stable(wdtctl_q)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the watchdog testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module watchdog_tb -f filelist.f -o watchdog_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/watchdog_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "test passed"; then
  exit 0
else
  exit 1
fi

// ==== test/watchdog_tb.sv ====
// Watchdog timer testbench
// Drives the peripheral bus and tick enables, runs a reference model of
// WDTCTL, the tick count, the flag and the reset pulse, and checks the DUT
// against the model with concurrent assertions

`include "wdt_config.svh"

module watchdog_tb;

  import wdt_pkg::*;

  localparam int          TIMEOUT_CYCLES = 20000;  // About ten times the full run
  localparam logic [15:0] CTL_BYTE_ADDR  = `WDT_BASE_ADDR;
  localparam per_addr_t   CTL_ADDR       = CTL_BYTE_ADDR[14:1];  // Word address
  localparam per_addr_t   OFF_ADDR       = CTL_ADDR + 14'd1;     // Next word in block
  localparam logic [7:0]  HOLD  = 8'h80;
  localparam logic [7:0]  TMSEL = 8'h10;
  localparam logic [7:0]  CNTCL = 8'h08;
  localparam logic [7:0]  SSEL  = 8'h04;

  logic       mclk;
  logic       puc_rst;
  per_addr_t  per_addr;
  per_data_t  per_din;
  logic       per_en;
  logic [1:0] per_we;
  logic       smclk_en;
  logic       aclk_en;
  logic       dbg_freeze;
  logic       wdtie;
  logic       wdtifg_sw_set;
  logic       wdtifg_sw_clr;
  logic       wdtifg_irq_clr;
  per_data_t  per_dout;
  logic       wdtifg;
  logic       wdt_irq;
  logic       wdt_reset;

  string       test_name = "reset";
  int          value_errors = 0;   // Assertion mismatches
  int          other_errors = 0;   // Missing events
  int          cycles = 0;
  logic [31:0] rnd;

  watchdog watchdog_i (.*);

  always #10 mclk = ~mclk;

  //--------------------------------------------------------------------------
  // Reference model
  //--------------------------------------------------------------------------

  logic [7:0] m_ctl;   // Expected WDTCTL low byte
  int         m_cnt;   // Enabled ticks since last restart
  logic       m_ifg;
  logic       m_rst;
  logic       m_rd, m_wr, m_bad, m_good, m_tick, m_exp, m_set;

  // Ticks per interval, indexed by isx
  function automatic int interval_ticks(input logic [1:0] isx);
    case (isx)
      2'd0:    return 32768;
      2'd1:    return 8192;
      2'd2:    return 512;
      default: return 64;
    endcase
  endfunction

  always_comb begin
    m_rd   = per_en && (per_addr == CTL_ADDR) && (per_we == 2'b00);
    m_wr   = per_en && (per_addr == CTL_ADDR) && (per_we != 2'b00);
    m_bad  = m_wr && (per_din[15:8] != `WDT_PASSWORD);
    m_good = m_wr && !m_bad;
    m_tick = (m_ctl[2] ? aclk_en : smclk_en) && !m_ctl[7] && !dbg_freeze;  // ssel, hold
    m_exp  = m_tick && (m_cnt + 1 == interval_ticks(m_ctl[1:0]));
    m_set  = m_exp || m_bad || wdtifg_sw_set;
  end

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      m_ctl <= 8'h00;
      m_cnt <= 0;
      m_ifg <= 1'b0;
      m_rst <= 1'b0;
    end else begin
      if (m_good) m_ctl <= per_din[7:0] & `WDTCTL_WR_MASK;
      if (m_bad || m_exp || (m_good && per_din[3])) begin
        m_cnt <= 0;  // Key error, expiry or cntcl
      end else if (m_tick) begin
        m_cnt <= m_cnt + 1;
      end
      if (m_set) begin
        m_ifg <= 1'b1;
      end else if (wdtifg_sw_clr || (wdtifg_irq_clr && m_ctl[4])) begin
        m_ifg <= 1'b0;
      end
      m_rst <= (m_bad || (m_set && !m_ctl[4])) && !m_rst;  // Single cycle pulse
    end
  end

  //--------------------------------------------------------------------------
  // Checks
  //--------------------------------------------------------------------------

  task automatic report_mismatch(input string sig, input logic [15:0] expected,
                                 input logic [15:0] actual);
    value_errors++;
    $display("[ERROR] %s: %s expected 0x%h, actual 0x%h", test_name, sig, expected, actual);
  endtask

  a_flag : assert property (@(posedge mclk) disable iff (puc_rst) wdtifg == m_ifg)
    else report_mismatch("wdtifg", 16'($sampled(m_ifg)), 16'($sampled(wdtifg)));
  a_irq : assert property (@(posedge mclk) disable iff (puc_rst)
    wdt_irq == (m_ctl[4] & m_ifg & wdtie))
    else report_mismatch("wdt_irq", 16'($sampled(m_ctl[4] & m_ifg & wdtie)),
                         16'($sampled(wdt_irq)));
  a_reset : assert property (@(posedge mclk) disable iff (puc_rst) wdt_reset == m_rst)
    else report_mismatch("wdt_reset", 16'($sampled(m_rst)), 16'($sampled(wdt_reset)));
  a_read : assert property (@(posedge mclk) disable iff (puc_rst)
    m_rd |-> per_dout == {`WDT_READ_ID, m_ctl})
    else report_mismatch("per_dout", {`WDT_READ_ID, $sampled(m_ctl)}, $sampled(per_dout));
  a_idle : assert property (@(posedge mclk) disable iff (puc_rst)
    !m_rd |-> per_dout == 16'h0000)  // Zero outside a WDTCTL read
    else report_mismatch("per_dout idle", 16'h0000, $sampled(per_dout));

  // Hard stop if something never finishes
  always @(posedge mclk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run still going after %0d cycles in %s", cycles, test_name);
      $display("test failed");
      $finish;
    end
  end

  //--------------------------------------------------------------------------
  // Bus and control tasks
  //--------------------------------------------------------------------------

  task automatic bus_write(input per_data_t data);
    @(negedge mclk);
    per_addr = CTL_ADDR;
    per_din  = data;
    per_en   = 1'b1;
    per_we   = 2'b11;
    @(negedge mclk);
    per_en   = 1'b0;
    per_we   = 2'b00;
    per_din  = '0;
  endtask

  task automatic bus_read(input per_addr_t addr);
    @(negedge mclk);
    per_addr = addr;
    per_en   = 1'b1;
    @(negedge mclk);
    per_en   = 1'b0;  // a_read checked at the edge between
  endtask

  task automatic ctrl_pulse(input logic set, input logic clr, input logic irq_clr);
    @(negedge mclk);
    wdtifg_sw_set  = set;
    wdtifg_sw_clr  = clr;
    wdtifg_irq_clr = irq_clr;
    @(negedge mclk);
    wdtifg_sw_set  = 1'b0;
    wdtifg_sw_clr  = 1'b0;
    wdtifg_irq_clr = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge mclk);
  endtask

  // Random tick enables until wdtifg or wdt_reset goes high
  task automatic wait_rise(input logic on_reset, input int max_cycles, input logic smclk_hi);
    int          n;
    logic [31:0] r;
    n = 0;
    while (((on_reset ? wdt_reset : wdtifg) == 1'b0) && (n < max_cycles)) begin
      @(negedge mclk);
      r        = $urandom();
      smclk_en = smclk_hi | r[0];
      aclk_en  = r[1];
      n++;
    end
    if ((on_reset ? wdt_reset : wdtifg) == 1'b0) begin
      other_errors++;
      $display("%s: %s never went high within %0d cycles", test_name,
               on_reset ? "wdt_reset" : "wdtifg", max_cycles);
    end
    smclk_en = 1'b0;
    aclk_en  = 1'b0;
  endtask

  function automatic logic [7:0] bad_key(input logic [7:0] r);
    return (r == `WDT_PASSWORD) ? 8'hA5 : r;
  endfunction

  //--------------------------------------------------------------------------
  // Stimulus
  //--------------------------------------------------------------------------

  initial begin
    void'($urandom(32'h8576));  // Seed once for the whole run
    mclk           = 1'b0;
    puc_rst        = 1'b1;
    per_addr       = '0;
    per_din        = '0;
    per_en         = 1'b0;
    per_we         = 2'b00;
    smclk_en       = 1'b0;
    aclk_en        = 1'b0;
    dbg_freeze     = 1'b0;
    wdtie          = 1'b0;
    wdtifg_sw_set  = 1'b0;
    wdtifg_sw_clr  = 1'b0;
    wdtifg_irq_clr = 1'b0;
    repeat (8) @(negedge mclk);
    puc_rst = 1'b0;

    test_name = "reg_access";
    rnd = $urandom();
    bus_read(CTL_ADDR);                         // 0x6900 after reset
    bus_write({`WDT_PASSWORD, rnd[7:0]});
    bus_read(CTL_ADDR);
    bus_write({bad_key(rnd[31:24]), rnd[15:8]});  // Rejected
    bus_read(CTL_ADDR);
    bus_read(OFF_ADDR);                         // Other word reads zero

    test_name = "pw_error";
    ctrl_pulse(1'b0, 1'b1, 1'b0);
    bus_write({`WDT_PASSWORD, CNTCL});          // Watchdog mode
    bus_write({bad_key(rnd[23:16]), 8'h00});
    idle(3);
    ctrl_pulse(1'b0, 1'b1, 1'b0);
    bus_write({`WDT_PASSWORD, TMSEL | CNTCL});  // Interval mode
    bus_write({bad_key(rnd[23:16]), 8'h00});
    idle(3);

    test_name = "interval_64";
    ctrl_pulse(1'b0, 1'b1, 1'b0);
    wdtie = 1'b1;
    bus_write({`WDT_PASSWORD, TMSEL | CNTCL | 8'h03});
    wait_rise(1'b0, 300, 1'b0);
    test_name = "interval_512";
    ctrl_pulse(1'b0, 1'b0, 1'b1);               // Accept clear
    bus_write({`WDT_PASSWORD, TMSEL | CNTCL | 8'h02});
    wait_rise(1'b0, 2200, 1'b0);

    test_name = "aclk_source";
    ctrl_pulse(1'b0, 1'b1, 1'b0);
    bus_write({`WDT_PASSWORD, TMSEL | SSEL | CNTCL | 8'h03});
    wait_rise(1'b0, 300, 1'b1);                 // smclk_en stuck high

    test_name = "hold_freeze";
    ctrl_pulse(1'b0, 1'b1, 1'b0);
    bus_write({`WDT_PASSWORD, HOLD | TMSEL | CNTCL | 8'h03});
    smclk_en = 1'b1;
    idle(100);
    bus_write({`WDT_PASSWORD, TMSEL | 8'h03});  // Release hold
    dbg_freeze = 1'b1;
    idle(100);
    dbg_freeze = 1'b0;
    wait_rise(1'b0, 300, 1'b0);

    test_name = "cnt_clear";
    ctrl_pulse(1'b0, 1'b1, 1'b0);
    smclk_en = 1'b1;
    idle(40);
    bus_write({`WDT_PASSWORD, TMSEL | CNTCL | 8'h03});
    wait_rise(1'b0, 300, 1'b0);

    test_name = "watchdog_64";
    ctrl_pulse(1'b0, 1'b1, 1'b0);
    bus_write({`WDT_PASSWORD, CNTCL | 8'h03});
    wait_rise(1'b1, 300, 1'b0);
    idle(2);
    ctrl_pulse(1'b0, 1'b0, 1'b1);               // No effect here
    ctrl_pulse(1'b0, 1'b1, 1'b0);

    test_name = "sw_flag";
    ctrl_pulse(1'b1, 1'b0, 1'b0);               // Also pulses wdt_reset
    idle(2);
    ctrl_pulse(1'b0, 1'b1, 1'b0);
    ctrl_pulse(1'b1, 1'b1, 1'b0);               // Set wins
    idle(2);
    bus_write({`WDT_PASSWORD, TMSEL});
    ctrl_pulse(1'b0, 1'b1, 1'b0);
    ctrl_pulse(1'b1, 1'b0, 1'b1);
    idle(2);

    $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
